//--- clMulCore.sv
`timescale 1ns/1ps
`include "gfMul_cfg.svh"

module clMulCore (
    input logic clk,
    input logic rst,
    clMulIf.core bus
);
    import gfMulPkg::*;

    localparam int CNT_W = $clog2(NUM_DIGITS);

    coreStateT state;
    logic [CNT_W-1:0] digitCnt;
    halfProdT aShift;   // multiplicand aligned to current digit
    halfT bShift;       // current digit sits in low bits
    halfProdT acc;
    halfProdT firstPart;
    halfProdT nextPart;

    // one digit worth of shift-and-xor
    function automatic halfProdT digitMul(input halfProdT a,
                                          input logic [`GFMUL_DIGIT-1:0] d);
        halfProdT r;
        r = '0;
        for (int j = 0; j < `GFMUL_DIGIT; j++) begin
            if (d[j]) begin
                r = r ^ (a << j);
            end
        end
        return r;
    endfunction

    assign firstPart = digitMul(halfProdT'(bus.opA), bus.opB[`GFMUL_DIGIT-1:0]);
    assign nextPart = digitMul(aShift, bShift[`GFMUL_DIGIT-1:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CORE_IDLE;
            digitCnt <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            case (state)
                CORE_IDLE: begin
                    if (bus.start) begin
                        state <= CORE_RUN;
                        digitCnt <= CNT_W'(1);  // digit 0 done at load
                    end
                end
                CORE_RUN: begin
                    digitCnt <= digitCnt + 1'b1;
                    if (digitCnt == CNT_W'(NUM_DIGITS - 1)) begin
                        state <= CORE_IDLE;
                        bus.done <= 1'b1;       // acc holds final product next cycle
                    end
                end
                default: state <= CORE_IDLE;
            endcase
        end
    end

    // accumulator is the cleared sum plus the first digit
    always_ff @(posedge clk) begin
        if (state == CORE_IDLE && bus.start) begin
            acc <= firstPart;
            aShift <= halfProdT'(bus.opA) << `GFMUL_DIGIT;
            bShift <= bus.opB >> `GFMUL_DIGIT;
        end else if (state == CORE_RUN) begin
            acc <= acc ^ nextPart;
            aShift <= aShift << `GFMUL_DIGIT;
            bShift <= bShift >> `GFMUL_DIGIT;
        end
    end

    assign bus.prod = acc;  // stable until next start

endmodule

//--- clMulIf.sv
`timescale 1ns/1ps

interface clMulIf (
    input logic clk
);
    import gfMulPkg::*;

    logic start;     // one-cycle request
    halfT opA;
    halfT opB;
    logic done;      // one-cycle completion
    halfProdT prod;  // held until next start

    modport seq (
        input  clk,
        output start, opA, opB,
        input  done, prod
    );

    modport core (
        input  clk,
        input  start, opA, opB,
        output done, prod
    );

endinterface

//--- gfMulPkg.sv
`include "gfMul_cfg.svh"

package gfMulPkg;

    localparam int HALF_W = `GFMUL_OP_W / 2;          // karatsuba split point
    localparam int NUM_DIGITS = HALF_W / `GFMUL_DIGIT; // core cycles per half product

    typedef logic [`GFMUL_WB_DW-1:0] wbDataT;
    typedef logic [`GFMUL_ADR_W-1:0] wbAdrT;
    typedef logic [`GFMUL_OP_W-1:0] operandT;
    typedef logic [HALF_W-1:0] halfT;
    typedef logic [2*HALF_W-1:0] halfProdT;         // top bit never set
    typedef logic [2*`GFMUL_OP_W-1:0] productT;     // top bit never set

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LOW,      // a0*b0 running
        SEQ_HIGH,     // a1*b1 running
        SEQ_MID,      // folded halves running
        SEQ_COMBINE
    } seqStateT;

    typedef enum logic {
        CORE_IDLE,
        CORE_RUN
    } coreStateT;

endpackage

//--- gfMulTb.sv
`timescale 1ns/1ps
`include "gfMul_cfg.svh"

module gfMulTb;
    import gfMulPkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int TIMEOUT = 200;            // cycles per ack, polls per multiply
    localparam logic [31:0] SEED = 32'd77452;

    localparam wbAdrT ADR_A = wbAdrT'('h00);
    localparam wbAdrT ADR_B = wbAdrT'('h08);
    localparam wbAdrT ADR_CTRL = wbAdrT'('h10);
    localparam wbAdrT ADR_STAT = wbAdrT'('h11);
    localparam wbAdrT ADR_RES = wbAdrT'('h20);
    localparam wbAdrT ADR_UNUSED = wbAdrT'('h30);

    logic clk;
    logic rst;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    wbAdrT wbAdr;
    wbDataT wbDatW;
    wbDataT wbDatR;
    logic wbAck;
    logic irq;

    logic [31:0] lfsrState = SEED;
    int irqCount = 0;

    gfMulTop dut0 (
        .clk    (clk),
        .rst    (rst),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .irq    (irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (!rst && irq) begin
            irqCount = irqCount + 1;  // one count per pulse cycle
        end
    end

    ////////////////////////////////////////////////////////////
    // reporting and reference model
    ////////////////////////////////////////////////////////////

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkEq(input string name, input wbDataT expected, input wbDataT actual);
        if (expected !== actual) begin
            abortRun($sformatf("FAIL %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    // galois form, one step per bit
    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h80200003;
        end
        return outBit;
    endfunction

    function automatic operandT randomOperand();
        operandT r;
        for (int i = 0; i < `GFMUL_OP_W; i++) begin
            r[i] = lfsrBit();
        end
        return r;
    endfunction

    // plain shift-and-xor over all 256 bits of b
    function automatic productT clmulRef(input operandT a, input operandT b);
        productT r;
        r = '0;
        for (int i = 0; i < `GFMUL_OP_W; i++) begin
            if (b[i]) begin
                r = r ^ (productT'(a) << i);
            end
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // bus access, entered and left on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic wbWrite(input wbAdrT adr, input wbDataT data);
        int waitCnt;
        waitCnt = 0;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b1;
        wbAdr = adr;
        wbDatW = data;
        @(negedge clk);
        while (wbAck !== 1'b1) begin
            if (waitCnt == TIMEOUT) begin
                abortRun($sformatf("no ack for write to address 0x%h", adr));
            end
            waitCnt++;
            @(negedge clk);
        end
        @(negedge clk);  // hold through the ack edge
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic wbRead(input wbAdrT adr, output wbDataT data);
        int waitCnt;
        waitCnt = 0;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b0;
        wbAdr = adr;
        @(negedge clk);
        while (wbAck !== 1'b1) begin
            if (waitCnt == TIMEOUT) begin
                abortRun($sformatf("no ack for read from address 0x%h", adr));
            end
            waitCnt++;
            @(negedge clk);
        end
        data = wbDatR;   // valid in the ack cycle
        @(negedge clk);
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    task automatic writeOperands(input operandT a, input operandT b);
        for (int i = 0; i < 8; i++) begin
            wbWrite(wbAdrT'(ADR_A + i), a[i*`GFMUL_WB_DW +: `GFMUL_WB_DW]);
            wbWrite(wbAdrT'(ADR_B + i), b[i*`GFMUL_WB_DW +: `GFMUL_WB_DW]);
        end
    endtask

    task automatic waitDone();
        wbDataT st;
        int polls;
        polls = 0;
        wbRead(ADR_STAT, st);
        while (st[1] !== 1'b1) begin
            if (polls == TIMEOUT) begin
                abortRun("multiply did not complete in time");
            end
            polls++;
            wbRead(ADR_STAT, st);
        end
    endtask

    task automatic compareResult(input productT expected);
        wbDataT w;
        for (int i = 0; i < 16; i++) begin
            wbRead(wbAdrT'(ADR_RES + i), w);
            checkEq($sformatf("result[%0d]", i), expected[i*`GFMUL_WB_DW +: `GFMUL_WB_DW], w);
        end
    endtask

    task automatic runMultiply(input operandT a, input operandT b, input productT expected);
        int irqBefore;
        wbDataT st;
        writeOperands(a, b);
        irqBefore = irqCount;
        wbWrite(ADR_CTRL, 32'h1);
        waitDone();
        checkEq("irq pulses", 32'h1, wbDataT'(irqCount - irqBefore));
        wbRead(ADR_STAT, st);
        checkEq("status", 32'h2, st);   // done, not busy
        compareResult(expected);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic testReset();
        wbDataT w;
        checkEq("irq", 32'h0, wbDataT'(irq));
        wbRead(ADR_STAT, w);
        checkEq("status", 32'h0, w);
        wbRead(ADR_CTRL, w);
        checkEq("control", 32'h0, w);
        wbRead(ADR_UNUSED, w);
        checkEq("unmapped 0x30", 32'h0, w);
        compareResult('0);
    endtask

    task automatic testReadback();
        operandT a;
        operandT b;
        wbDataT w;
        a = randomOperand();
        b = randomOperand();
        writeOperands(a, b);
        for (int i = 0; i < 8; i++) begin
            wbRead(wbAdrT'(ADR_A + i), w);
            checkEq($sformatf("A[%0d]", i), a[i*`GFMUL_WB_DW +: `GFMUL_WB_DW], w);
            wbRead(wbAdrT'(ADR_B + i), w);
            checkEq($sformatf("B[%0d]", i), b[i*`GFMUL_WB_DW +: `GFMUL_WB_DW], w);
        end
    endtask

    task automatic testDirected();
        operandT b;
        operandT top;
        b = randomOperand();
        runMultiply(operandT'(1), b, productT'(b));     // identity
        top = operandT'(1) << (`GFMUL_OP_W - 1);
        runMultiply(top, top, productT'(1) << (2 * `GFMUL_OP_W - 2));
    endtask

    task automatic testRandom();
        operandT a;
        operandT b;
        for (int n = 0; n < 3; n++) begin
            a = randomOperand();
            b = randomOperand();
            runMultiply(a, b, clmulRef(a, b));
        end
    endtask

    task automatic testBusy();
        operandT a;
        operandT b;
        wbDataT w;
        int irqBefore;
        a = randomOperand();
        b = randomOperand();
        writeOperands(a, b);
        irqBefore = irqCount;
        wbWrite(ADR_CTRL, 32'h1);
        wbRead(ADR_STAT, w);
        checkEq("status", 32'h1, w);          // busy, old done cleared
        wbWrite(ADR_A, ~a[31:0]);             // must be dropped
        wbWrite(ADR_CTRL, 32'h1);             // second start dropped too
        waitDone();
        checkEq("irq pulses", 32'h1, wbDataT'(irqCount - irqBefore));
        compareResult(clmulRef(a, b));
        wbRead(ADR_A, w);
        checkEq("A[0]", a[31:0], w);
        // restart after completion
        irqBefore = irqCount;
        wbWrite(ADR_CTRL, 32'h1);
        wbRead(ADR_STAT, w);
        checkEq("status", 32'h1, w);
        waitDone();
        checkEq("irq pulses", 32'h1, wbDataT'(irqCount - irqBefore));
        compareResult(clmulRef(a, b));
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        testReset();
        testReadback();
        testDirected();
        testRandom();
        testBusy();
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- gfMulTop.sv
`timescale 1ns/1ps

module gfMulTop (
    input  logic clk,
    input  logic rst,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  gfMulPkg::wbAdrT wbAdr,
    input  gfMulPkg::wbDataT wbDatW,
    output gfMulPkg::wbDataT wbDatR,
    output logic wbAck,
    output logic irq
);
    import gfMulPkg::*;

    logic go;
    logic busy;
    logic finish;
    operandT opA;
    operandT opB;
    productT result;

    clMulIf mulBus (.clk(clk));  // sequencer to core

    wbRegBank regBank0 (
        .clk    (clk),
        .rst    (rst),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .busy   (busy),
        .finish (finish),
        .result (result),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .go     (go),
        .opA    (opA),
        .opB    (opB),
        .irq    (irq)
    );

    karatsubaSeq seq0 (
        .clk    (clk),
        .rst    (rst),
        .go     (go),
        .opA    (opA),
        .opB    (opB),
        .busy   (busy),
        .finish (finish),
        .result (result),
        .mul    (mulBus.seq)
    );

    clMulCore core0 (
        .clk (clk),
        .rst (rst),
        .bus (mulBus.core)
    );

endmodule

//--- gfMul_assert.sv
`timescale 1ns/1ps

module gfMulAssert (
    input logic clk,
    input logic rst,
    input logic wbCyc,
    input logic wbStb,
    input logic wbAck,
    input logic irq
);

    // ack only inside an active request
    ackInRequest: assert property (@(posedge clk) disable iff (rst)
        wbAck |-> (wbCyc && wbStb))
        else $error("ack seen without cyc and stb");

    // ack answers a request from the cycle before
    ackHasRequest: assert property (@(posedge clk) disable iff (rst)
        wbAck |-> $past(wbCyc && wbStb))
        else $error("ack without a preceding request");

    ackSingle: assert property (@(posedge clk) disable iff (rst)
        wbAck |=> !wbAck)
        else $error("ack high for two cycles in a row");

    irqSingle: assert property (@(posedge clk) disable iff (rst)
        irq |=> !irq)
        else $error("irq high for two cycles in a row");

endmodule

bind gfMulTop gfMulAssert busChecks0 (
    .clk   (clk),
    .rst   (rst),
    .wbCyc (wbCyc),
    .wbStb (wbStb),
    .wbAck (wbAck),
    .irq   (irq)
);

//--- gfMul_cfg.svh
`ifndef GFMUL_CFG_SVH
`define GFMUL_CFG_SVH

////////////////////////////////////////////////////////////
// bus geometry
////////////////////////////////////////////////////////////

`define GFMUL_WB_DW 32   // wishbone data width
`define GFMUL_ADR_W 6    // word address width

////////////////////////////////////////////////////////////
// multiplier geometry
////////////////////////////////////////////////////////////

`define GFMUL_OP_W  256  // full operand width
`define GFMUL_DIGIT 8    // operand bits per core cycle

`endif

//--- karatsubaSeq.sv
`timescale 1ns/1ps

module karatsubaSeq (
    input  logic clk,
    input  logic rst,
    input  logic go,
    input  gfMulPkg::operandT opA,
    input  gfMulPkg::operandT opB,
    output logic busy,
    output logic finish,
    output gfMulPkg::productT result,
    clMulIf.seq mul
);
    import gfMulPkg::*;

    seqStateT state;
    halfT a0;
    halfT a1;
    halfT b0;
    halfT b1;
    halfProdT lowProd;   // a0*b0
    halfProdT highProd;  // a1*b1
    halfProdT midTerm;

    assign a0 = opA[HALF_W-1:0];
    assign a1 = opA[2*HALF_W-1:HALF_W];
    assign b0 = opB[HALF_W-1:0];
    assign b1 = opB[2*HALF_W-1:HALF_W];

    // core output is still the folded product while combining
    assign midTerm = mul.prod ^ lowProd ^ highProd;

    assign busy = (state != SEQ_IDLE);

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
            mul.start <= 1'b0;
            finish <= 1'b0;
        end else begin
            mul.start <= 1'b0;
            finish <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (go) begin
                        mul.start <= 1'b1;
                        state <= SEQ_LOW;
                    end
                end
                SEQ_LOW: begin
                    if (mul.done) begin
                        mul.start <= 1'b1;
                        state <= SEQ_HIGH;
                    end
                end
                SEQ_HIGH: begin
                    if (mul.done) begin
                        mul.start <= 1'b1;
                        state <= SEQ_MID;
                    end
                end
                SEQ_MID: begin
                    if (mul.done) begin
                        state <= SEQ_COMBINE;
                    end
                end
                SEQ_COMBINE: begin
                    finish <= 1'b1;  // result valid with this pulse
                    state <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // operands and partial products
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && go) begin
            mul.opA <= a0;
            mul.opB <= b0;
        end else if (state == SEQ_LOW && mul.done) begin
            lowProd <= mul.prod;
            mul.opA <= a1;
            mul.opB <= b1;
        end else if (state == SEQ_HIGH && mul.done) begin
            highProd <= mul.prod;
            mul.opA <= a0 ^ a1;  // folded halves
            mul.opB <= b0 ^ b1;
        end
        if (state == SEQ_COMBINE) begin
            result <= productT'(lowProd)
                    ^ (productT'(highProd) << (2 * HALF_W))
                    ^ (productT'(midTerm) << HALF_W);
        end
    end

endmodule

//--- project.f
+incdir+.
gfMulPkg.sv
clMulIf.sv
clMulCore.sv
karatsubaSeq.sv
wbRegBank.sv
gfMulTop.sv
gfMul_assert.sv
gfMulTb.sv

//--- run.sh
#!/bin/sh
# build and run the gfMul testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module gfMulTb -f project.f -o gfMulSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/gfMulSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Testbench passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- wbRegBank.sv
`timescale 1ns/1ps
`include "gfMul_cfg.svh"

module wbRegBank (
    input  logic clk,
    input  logic rst,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  gfMulPkg::wbAdrT wbAdr,
    input  gfMulPkg::wbDataT wbDatW,
    input  logic busy,
    input  logic finish,
    input  gfMulPkg::productT result,
    output gfMulPkg::wbDataT wbDatR,
    output logic wbAck,
    output logic go,
    output gfMulPkg::operandT opA,
    output gfMulPkg::operandT opB,
    output logic irq
);
    import gfMulPkg::*;

    localparam wbAdrT ADR_CTRL = wbAdrT'('h10);
    localparam wbAdrT ADR_STAT = wbAdrT'('h11);

    logic req;
    logic newReq;     // request not yet acked
    logic wrStrobe;   // write data taken here
    logic startReq;
    logic isA;
    logic isB;
    logic isCtrl;
    logic isStat;
    logic isRes;
    logic doneFlag;
    productT resultReg;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    assign req = wbCyc & wbStb;
    assign newReq = req & ~wbAck;
    assign wrStrobe = wbAck & wbWe;

    assign isA = (wbAdr[5:3] == 3'b000);    // 0x00..0x07
    assign isB = (wbAdr[5:3] == 3'b001);    // 0x08..0x0f
    assign isCtrl = (wbAdr == ADR_CTRL);
    assign isStat = (wbAdr == ADR_STAT);
    assign isRes = (wbAdr[5:4] == 2'b10);   // 0x20..0x2f

    // start only honoured when idle
    assign startReq = newReq & wbWe & isCtrl & wbDatW[0] & ~busy;

    ////////////////////////////////////////////////////////////
    // handshake, start and completion
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wbAck <= 1'b0;
            go <= 1'b0;
            irq <= 1'b0;
            doneFlag <= 1'b0;
        end else begin
            wbAck <= newReq;    // single cycle, never back to back
            go <= startReq;     // lines up with the ack
            irq <= finish;
            if (finish) begin
                doneFlag <= 1'b1;
            end else if (startReq) begin
                doneFlag <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // operand and result storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            opA <= '0;
            opB <= '0;
            resultReg <= '0;
        end else begin
            if (wrStrobe && !busy && isA) begin
                opA[wbAdr[2:0]*`GFMUL_WB_DW +: `GFMUL_WB_DW] <= wbDatW;
            end
            if (wrStrobe && !busy && isB) begin
                opB[wbAdr[2:0]*`GFMUL_WB_DW +: `GFMUL_WB_DW] <= wbDatW;
            end
            if (finish) begin
                resultReg <= result;
            end
        end
    end

    // read data only driven in the ack cycle
    always_comb begin
        wbDatR = '0;
        if (wbAck && !wbWe) begin
            if (isA) begin
                wbDatR = opA[wbAdr[2:0]*`GFMUL_WB_DW +: `GFMUL_WB_DW];
            end else if (isB) begin
                wbDatR = opB[wbAdr[2:0]*`GFMUL_WB_DW +: `GFMUL_WB_DW];
            end else if (isStat) begin
                wbDatR = wbDataT'({doneFlag, busy});
            end else if (isRes) begin
                wbDatR = resultReg[wbAdr[3:0]*`GFMUL_WB_DW +: `GFMUL_WB_DW];
            end
        end
    end

endmodule
